//--- flist.f
+incdir+source
source/conv_ctrl_pkg.sv
source/load_addr_counter.sv
source/conv_loop_nest.sv
source/conv_ctrl_fsm.sv
source/conv_controller_top.sv
dv/conv_controller_tb.sv

//--- Makefile
# Verilator build and run of the controller testbench

VERILATOR ?= verilator
TOP       ?= conv_controller_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Done: no errors

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/conv_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_ctrl_consts.svh"

module conv_controller_tb;

  localparam int K = `CONV_KERNEL;
  localparam int ROW_STEPS = `CONV_X_TILES * `CONV_OUT_TILES * `CONV_IN_CHANNELS * K * K;
  localparam int STEPS = `CONV_FM_HEIGHT * ROW_STEPS;
  // top and bottom padded kernel rows carry no MAC
  localparam int MACS = STEPS - 2 * ROW_STEPS / K;
  localparam int WEIGHT_WORDS = `CONV_WEIGHT_WORDS;
  localparam int ACT_WORDS = `CONV_ACT_WORDS;
  localparam int RUNS = 2;
  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD = 10;
  localparam int WATCHDOG_CYCLES = 4 * (RUNS * STEPS + 34) + RESET_CYCLES;

  logic clk = 1'b0;
  logic arst_n_in = 1'b0;
  logic start = 1'b0;
  logic weights_valid = 1'b0;
  logic activations_valid = 1'b0;
  logic operand_ready = 1'b0;
  logic running, weights_ready, activations_ready;
  logic write_weights_memory_n, write_activations_memory_n, read_weights_memory_n;
  logic mac_valid, mac_accumulate;
  conv_ctrl_pkg::w_addr_t address_weights;
  conv_ctrl_pkg::act_addr_t address_activations;
  conv_ctrl_pkg::kernel_idx_t fx, fy;

  logic [31:0] lfsr = 32'haa14_82f9;
  int errors = 0;
  int w_count, a_count, mac_count, model_pos;
  conv_ctrl_pkg::kernel_idx_t exp_fx, exp_fy;
  conv_ctrl_pkg::w_addr_t exp_waddr;
  logic exp_acc;

  conv_controller_top UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // right shifting Galois LFSR stepped once per bit
  function automatic logic next_random_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
    return b;
  endfunction

  function automatic bit is_padding(input int pos);
    int y, k_v;
    y = pos / ROW_STEPS;
    k_v = (pos / K) % K;
    return (y == 0 && k_v == 0) || (y == `CONV_FM_HEIGHT - 1 && k_v == K - 1);
  endfunction

  function automatic int next_real(input int pos);
    int p;
    p = pos;
    while (p < STEPS && is_padding(p)) begin
      p = p + 1;
    end
    return p;
  endfunction

  function automatic logic accumulate_for(input int pos);
    int y, ch_in, k_v, k_h;
    y = pos / ROW_STEPS;
    ch_in = (pos / (K * K)) % `CONV_IN_CHANNELS;
    k_v = (pos / K) % K;
    k_h = pos % K;
    return !((ch_in == 0 && k_v == 0 && k_h == 0) ||
             (y == 0 && ch_in == 0 && k_v == 1 && k_h == 0));
  endfunction

  task automatic report_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    errors++;
    $display("ERR %s expected %h actual %h at %0t", name, expected, actual, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("error at %0t: %s", $time, what);
  endtask

  always_comb begin
    exp_fx    = conv_ctrl_pkg::kernel_idx_t'(model_pos % K);
    exp_fy    = conv_ctrl_pkg::kernel_idx_t'((model_pos / K) % K);
    exp_waddr = conv_ctrl_pkg::w_addr_t'(model_pos % WEIGHT_WORDS);
    exp_acc   = accumulate_for(model_pos);
  end

  // acceptance counters and the loop order model
  always @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in || !running) begin
      w_count   <= 0;
      a_count   <= 0;
      mac_count <= 0;
      model_pos <= next_real(0);
    end else begin
      if (weights_ready && weights_valid) w_count <= w_count + 1;
      if (activations_ready && activations_valid) a_count <= a_count + 1;
      if (mac_valid) begin
        mac_count <= mac_count + 1;
        model_pos <= next_real(model_pos + 1);
      end
    end
  end

  // one LFSR bit per handshake level
  always @(negedge clk) begin
    weights_valid     = next_random_bit();
    activations_valid = next_random_bit();
    operand_ready     = next_random_bit();
  end

  assert property (@(posedge clk) disable iff (!arst_n_in) !running |-> (!weights_ready &&
    !activations_ready && !mac_valid && write_weights_memory_n &&
    write_activations_memory_n && read_weights_memory_n))
  else report_failure("idle controller shows an active output");

  assert property (@(posedge clk) disable iff (!arst_n_in)
    weights_ready && weights_valid |-> !write_weights_memory_n)
  else report_failure("weight word accepted without a write strobe");
  assert property (@(posedge clk) disable iff (!arst_n_in) weights_ready && weights_valid
    |-> address_weights == conv_ctrl_pkg::w_addr_t'(w_count))
  else report_value("address_weights", 32'($sampled(w_count)), 32'($sampled(address_weights)));
  assert property (@(posedge clk) disable iff (!arst_n_in) weights_ready |-> w_count < WEIGHT_WORDS)
  else report_failure("weights_ready open after the last weight word");

  assert property (@(posedge clk) disable iff (!arst_n_in)
    activations_ready && activations_valid |-> !write_activations_memory_n)
  else report_failure("activation word accepted without a write strobe");
  assert property (@(posedge clk) disable iff (!arst_n_in) activations_ready && activations_valid
    |-> address_activations == conv_ctrl_pkg::act_addr_t'(`CONV_ACT_START + a_count))
  else report_value("address_activations", 32'(`CONV_ACT_START + $sampled(a_count)),
                    32'($sampled(address_activations)));
  assert property (@(posedge clk) disable iff (!arst_n_in)
    activations_ready |-> a_count < ACT_WORDS && !weights_ready)
  else report_failure("activations_ready open out of its load phase");

  assert property (@(posedge clk) disable iff (!arst_n_in) mac_valid |-> operand_ready)
  else report_failure("mac_valid raised without operand_ready");
  assert property (@(posedge clk) disable iff (!arst_n_in) read_weights_memory_n == !mac_valid)
  else report_failure("weight read strobe does not follow mac_valid");
  assert property (@(posedge clk) disable iff (!arst_n_in) mac_valid |-> model_pos < STEPS)
  else report_failure("MAC issued past the last loop position");
  assert property (@(posedge clk) disable iff (!arst_n_in) mac_valid |-> fx == exp_fx)
  else report_value("fx", 32'($sampled(exp_fx)), 32'($sampled(fx)));
  assert property (@(posedge clk) disable iff (!arst_n_in) mac_valid |-> fy == exp_fy)
  else report_value("fy", 32'($sampled(exp_fy)), 32'($sampled(fy)));
  assert property (@(posedge clk) disable iff (!arst_n_in)
    mac_valid |-> address_weights == exp_waddr)
  else report_value("address_weights", 32'($sampled(exp_waddr)), 32'($sampled(address_weights)));
  assert property (@(posedge clk) disable iff (!arst_n_in) mac_valid |-> mac_accumulate == exp_acc)
  else report_value("mac_accumulate", 32'($sampled(exp_acc)), 32'($sampled(mac_accumulate)));

  // counters still hold the finished run when running falls
  assert property (@(posedge clk) disable iff (!arst_n_in) $fell(running) |-> mac_count == MACS)
  else report_value("mac_valid count", 32'(MACS), 32'($sampled(mac_count)));
  assert property (@(posedge clk) disable iff (!arst_n_in) $fell(running) |-> a_count == ACT_WORDS)
  else report_value("activation count", 32'(ACT_WORDS), 32'($sampled(a_count)));
  assert property (@(posedge clk) disable iff (!arst_n_in)
    $fell(running) |-> w_count == WEIGHT_WORDS)
  else report_value("weight count", 32'(WEIGHT_WORDS), 32'($sampled(w_count)));

  initial begin
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n_in = 1'b1;
    for (int run = 0; run < RUNS; run++) begin
      repeat (3) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (running) @(negedge clk);
    end
    repeat (3) @(negedge clk);
    $display("runs %0d, errors %0d", RUNS, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: the controller did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("runs %0d, errors %0d", RUNS, errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/conv_controller_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_ctrl_consts.svh"

module conv_controller_top (
  input  logic                       clk,
  input  logic                       arst_n_in,
  input  logic                       start,
  input  logic                       weights_valid,
  input  logic                       activations_valid,
  input  logic                       operand_ready,
  output logic                       running,
  output logic                       weights_ready,
  output logic                       activations_ready,
  output logic                       write_weights_memory_n,
  output conv_ctrl_pkg::w_addr_t     address_weights,
  output logic                       write_activations_memory_n,
  output conv_ctrl_pkg::act_addr_t   address_activations,
  output logic                       read_weights_memory_n,
  output logic                       mac_valid,
  output logic                       mac_accumulate,
  output conv_ctrl_pkg::kernel_idx_t fx,
  output conv_ctrl_pkg::kernel_idx_t fy
);

  logic step, padding_step, last_step;
  logic weight_clear, weight_enable, weight_at_wrap;
  logic act_clear, act_enable;

  conv_ctrl_fsm u_fsm (
    .clk                        (clk),
    .arst_n_in                  (arst_n_in),
    .start                      (start),
    .weights_valid              (weights_valid),
    .activations_valid          (activations_valid),
    .operand_ready              (operand_ready),
    .padding_step               (padding_step),
    .last_step                  (last_step),
    .weight_at_wrap             (weight_at_wrap),
    .activation_addr            (address_activations),
    .running                    (running),
    .weights_ready              (weights_ready),
    .activations_ready          (activations_ready),
    .write_weights_memory_n     (write_weights_memory_n),
    .write_activations_memory_n (write_activations_memory_n),
    .read_weights_memory_n      (read_weights_memory_n),
    .mac_valid                  (mac_valid),
    .step                       (step),
    .weight_clear               (weight_clear),
    .weight_enable              (weight_enable),
    .act_clear                  (act_clear),
    .act_enable                 (act_enable)
  );

  // nest restarts together with the weight counter
  conv_loop_nest u_loop_nest (
    .clk            (clk),
    .arst_n_in      (arst_n_in),
    .clear          (weight_clear),
    .step           (step),
    .fx             (fx),
    .fy             (fy),
    .mac_accumulate (mac_accumulate),
    .padding_step   (padding_step),
    .last_step      (last_step)
  );

  // one output pixel worth of weights per wrap
  load_addr_counter #(
    .addr_t    (conv_ctrl_pkg::w_addr_t),
    .LAST_ADDR (conv_ctrl_pkg::w_addr_t'(`CONV_WEIGHT_WORDS - 1))
  ) u_weight_counter (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .clear       (weight_clear),
    .enable      (weight_enable),
    .clear_value (conv_ctrl_pkg::w_addr_t'(0)),
    .addr        (address_weights),
    .at_wrap     (weight_at_wrap)
  );

  // wraps at the top of the activation memory
  load_addr_counter #(
    .addr_t    (conv_ctrl_pkg::act_addr_t),
    .LAST_ADDR (conv_ctrl_pkg::act_addr_t'((1 << `CONV_ACT_ADDR_WIDTH) - 1))
  ) u_act_counter (
    .clk         (clk),
    .arst_n_in   (arst_n_in),
    .clear       (act_clear),
    .enable      (act_enable),
    .clear_value (conv_ctrl_pkg::act_addr_t'(`CONV_ACT_START)),
    .addr        (address_activations),
    .at_wrap     ()
  );

endmodule

`default_nettype wire

//--- source/conv_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_ctrl_consts.svh"

module conv_ctrl_fsm (
  input  logic                     clk,
  input  logic                     arst_n_in,
  input  logic                     start,
  input  logic                     weights_valid,
  input  logic                     activations_valid,
  input  logic                     operand_ready,
  input  logic                     padding_step,
  input  logic                     last_step,
  input  logic                     weight_at_wrap,
  input  conv_ctrl_pkg::act_addr_t activation_addr,
  output logic                     running,
  output logic                     weights_ready,
  output logic                     activations_ready,
  output logic                     write_weights_memory_n,
  output logic                     write_activations_memory_n,
  output logic                     read_weights_memory_n,
  output logic                     mac_valid,
  output logic                     step,
  output logic                     weight_clear,
  output logic                     weight_enable,
  output logic                     act_clear,
  output logic                     act_enable
);

  // address of the final activation word of a load
  localparam conv_ctrl_pkg::act_addr_t ACT_LAST =
    conv_ctrl_pkg::act_addr_t'(`CONV_ACT_START + `CONV_ACT_WORDS - 1);

  conv_ctrl_pkg::ctrl_state_t state;
  conv_ctrl_pkg::ctrl_state_t next_state;

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      state <= conv_ctrl_pkg::IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state                 = state;
    running                    = 1'b1;
    weights_ready              = 1'b0;
    activations_ready          = 1'b0;
    write_weights_memory_n     = 1'b1;
    write_activations_memory_n = 1'b1;
    read_weights_memory_n      = 1'b1;
    mac_valid                  = 1'b0;
    step                       = 1'b0;
    weight_clear               = 1'b0;
    weight_enable              = 1'b0;
    act_clear                  = 1'b0;
    act_enable                 = 1'b0;

    case (state)
      conv_ctrl_pkg::IDLE: begin
        running      = 1'b0;
        // counters and loop nest held at their start values
        weight_clear = 1'b1;
        act_clear    = 1'b1;
        if (start) begin
          next_state = conv_ctrl_pkg::LOAD_WEIGHTS;
        end
      end

      conv_ctrl_pkg::LOAD_WEIGHTS: begin
        weights_ready          = 1'b1;
        write_weights_memory_n = !weights_valid;
        weight_enable          = weights_valid;
        if (weights_valid && weight_at_wrap) begin
          next_state = conv_ctrl_pkg::LOAD_ACTIVATIONS;
        end
      end

      conv_ctrl_pkg::LOAD_ACTIVATIONS: begin
        activations_ready          = 1'b1;
        write_activations_memory_n = !activations_valid;
        act_enable                 = activations_valid;
        if (activations_valid && activation_addr == ACT_LAST) begin
          next_state = conv_ctrl_pkg::COMPUTE;
        end
      end

      conv_ctrl_pkg::COMPUTE: begin
        // padding steps never wait for the decoder
        step                  = padding_step || operand_ready;
        mac_valid             = operand_ready && !padding_step;
        read_weights_memory_n = !mac_valid;
        weight_enable         = step;
        if (step && last_step) begin
          next_state = conv_ctrl_pkg::IDLE;
        end
      end

      default: begin
        next_state = conv_ctrl_pkg::IDLE;
      end
    endcase
  end

  assert property (@(posedge clk) disable iff (!arst_n_in)
    !(weights_ready && activations_ready))
  else $error("both load handshakes open at once");

  assert property (@(posedge clk) disable iff (!arst_n_in)
    mac_valid |-> operand_ready)
  else $error("MAC issued without operands");

endmodule

`default_nettype wire

//--- source/conv_loop_nest.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_ctrl_consts.svh"

module conv_loop_nest (
  input  logic                       clk,
  input  logic                       arst_n_in,
  input  logic                       clear,
  input  logic                       step,
  output conv_ctrl_pkg::kernel_idx_t fx,
  output conv_ctrl_pkg::kernel_idx_t fy,
  output logic                       mac_accumulate,
  output logic                       padding_step,
  output logic                       last_step
);

  localparam conv_ctrl_pkg::loop_idx_t Y_LAST =
    conv_ctrl_pkg::loop_idx_t'(`CONV_FM_HEIGHT - 1);
  localparam conv_ctrl_pkg::loop_idx_t X_LAST =
    conv_ctrl_pkg::loop_idx_t'(`CONV_X_TILES - 1);
  localparam conv_ctrl_pkg::loop_idx_t CH_OUT_LAST =
    conv_ctrl_pkg::loop_idx_t'(`CONV_OUT_TILES - 1);
  localparam conv_ctrl_pkg::loop_idx_t CH_IN_LAST =
    conv_ctrl_pkg::loop_idx_t'(`CONV_IN_CHANNELS - 1);
  localparam conv_ctrl_pkg::loop_idx_t K_LAST =
    conv_ctrl_pkg::loop_idx_t'(`CONV_KERNEL - 1);

  conv_ctrl_pkg::loop_idx_t y, x, ch_out, ch_in, k_v, k_h;

  logic last_y, last_x, last_ch_out, last_ch_in, last_k_v, last_k_h;
  logic carry_k_v, carry_ch_in, carry_ch_out, carry_x, carry_y;

  assign last_y      = (y == Y_LAST);
  assign last_x      = (x == X_LAST);
  assign last_ch_out = (ch_out == CH_OUT_LAST);
  assign last_ch_in  = (ch_in == CH_IN_LAST);
  assign last_k_v    = (k_v == K_LAST);
  assign last_k_h    = (k_h == K_LAST);

  // a counter moves when every inner counter sits at its last value
  assign carry_k_v    = last_k_h;
  assign carry_ch_in  = carry_k_v && last_k_v;
  assign carry_ch_out = carry_ch_in && last_ch_in;
  assign carry_x      = carry_ch_out && last_ch_out;
  assign carry_y      = carry_x && last_x;

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      {y, x, ch_out, ch_in, k_v, k_h} <= '0;
    end else if (clear) begin
      {y, x, ch_out, ch_in, k_v, k_h} <= '0;
    end else if (step) begin
      k_h <= last_k_h ? '0 : k_h + 1'b1;
      if (carry_k_v) begin
        k_v <= last_k_v ? '0 : k_v + 1'b1;
      end
      if (carry_ch_in) begin
        ch_in <= last_ch_in ? '0 : ch_in + 1'b1;
      end
      if (carry_ch_out) begin
        ch_out <= last_ch_out ? '0 : ch_out + 1'b1;
      end
      if (carry_x) begin
        x <= last_x ? '0 : x + 1'b1;
      end
      if (carry_y) begin
        y <= last_y ? '0 : y + 1'b1;
      end
    end
  end

  assign fx = conv_ctrl_pkg::kernel_idx_t'(k_h);
  assign fy = conv_ctrl_pkg::kernel_idx_t'(k_v);

  // kernel rows above the first and below the last image row
  assign padding_step = (y == '0 && k_v == '0) || (last_y && last_k_v);

  // new sum at the first tap; on the top row the first tap is padding
  assign mac_accumulate = !((ch_in == '0 && k_v == '0 && k_h == '0) ||
                            (y == '0 && ch_in == '0 && k_v == 8'd1 && k_h == '0));

  assign last_step = carry_y && last_y;

  assert property (@(posedge clk) disable iff (!arst_n_in)
    (y <= Y_LAST) && (x <= X_LAST) && (ch_out <= CH_OUT_LAST) &&
    (ch_in <= CH_IN_LAST) && (k_v <= K_LAST) && (k_h <= K_LAST))
  else $error("loop counter beyond its bound");

endmodule

`default_nettype wire

//--- source/load_addr_counter.sv
`timescale 1ns/1ps
`default_nettype none

module load_addr_counter #(
  parameter type addr_t = logic [7:0],
  parameter addr_t LAST_ADDR = '1
) (
  input  logic  clk,
  input  logic  arst_n_in,
  input  logic  clear,
  input  logic  enable,
  input  addr_t clear_value,
  output addr_t addr,
  output logic  at_wrap
);

  always_ff @(posedge clk or negedge arst_n_in) begin
    if (!arst_n_in) begin
      addr <= '0;
    end else if (clear) begin
      addr <= clear_value;
    end else if (enable) begin
      // back to zero once the last address is written
      if (addr == LAST_ADDR) begin
        addr <= '0;
      end else begin
        addr <= addr_t'(addr + 1'b1);
      end
    end
  end

  assign at_wrap = (addr == LAST_ADDR);

  // the sequencer only clears while idle and only counts while busy
  assert property (@(posedge clk) disable iff (!arst_n_in)
    !(clear && enable))
  else $error("address counter cleared and enabled in the same cycle");

endmodule

`default_nettype wire

//--- source/conv_ctrl_pkg.sv
`default_nettype none

`include "conv_ctrl_consts.svh"

package conv_ctrl_pkg;

  // top level sequencing of one run
  typedef enum logic [1:0] {
    IDLE,
    LOAD_WEIGHTS,
    LOAD_ACTIVATIONS,
    COMPUTE
  } ctrl_state_t;

  typedef logic [`CONV_W_ADDR_WIDTH-1:0] w_addr_t;
  typedef logic [`CONV_ACT_ADDR_WIDTH-1:0] act_addr_t;

  typedef logic [7:0] loop_idx_t;
  // kernel tap position, fx and fy
  typedef logic [1:0] kernel_idx_t;

endpackage

`default_nettype wire

//--- source/conv_ctrl_consts.svh
`ifndef CONV_CTRL_CONSTS_SVH
`define CONV_CTRL_CONSTS_SVH

// feature map and kernel geometry
`define CONV_FM_WIDTH 32
`define CONV_FM_HEIGHT 4
`define CONV_IN_CHANNELS 2
`define CONV_OUT_CHANNELS 16
`define CONV_KERNEL 3

// pixels or channels per memory word
`define CONV_LANES 16
`define CONV_X_TILES ((`CONV_FM_WIDTH + `CONV_LANES - 1) / `CONV_LANES)
`define CONV_OUT_TILES ((`CONV_OUT_CHANNELS + `CONV_LANES - 1) / `CONV_LANES)

// words moved per load phase
`define CONV_WEIGHT_WORDS \
  (`CONV_KERNEL * `CONV_KERNEL * `CONV_IN_CHANNELS * `CONV_OUT_CHANNELS / `CONV_LANES)
`define CONV_ACT_WORDS (`CONV_FM_HEIGHT * `CONV_X_TILES * `CONV_IN_CHANNELS)
`define CONV_ACT_START 0

`define CONV_W_ADDR_WIDTH 12
`define CONV_ACT_ADDR_WIDTH 14

`endif
